/* lc3b_core.f */
lc3b_pkg.sv
mem_if.sv
decode_if.sv
lc3b_decode.sv
lc3b_regfile.sv
lc3b_alu.sv
datapath.sv
lc3b_core.sv
lc3b_core_properties.sv
tb_lc3b_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_lc3b_core
FILELIST  = lc3b_core.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
RUN_ARGS  = +verilator+error+limit+1000
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUN_ARGS) | tee $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_lc3b_core.sv */
module tb_lc3b_core;
    import lc3b_pkg::*;

    localparam int base_seed  = 32'h3e562a35;
    localparam int num_groups = 400;
    localparam int max_cycles = num_groups * 5 * 8;
    localparam int mem_words  = 32768;

    logic     clk = 1'b0;
    logic     reset = 1'b1;
    lc3b_word i_mem_address;
    logic     i_mem_read;
    logic     i_mem_resp = 1'b0;
    lc3b_word i_mem_rdata = 16'h0000;
    lc3b_word d_mem_address;
    logic     d_mem_read;
    logic     d_mem_write;
    lc3b_word d_mem_wdata;
    lc3b_word d_mem_rdata = 16'h0000;
    logic     d_mem_resp = 1'b0;

    integer   prog_seed = base_seed;
    integer   i_seed = base_seed ^ 32'h0000_0001;
    integer   d_seed = base_seed ^ 32'h0000_0002;
    logic [1:0] i_wait = 2'd0;
    logic [1:0] d_wait = 2'd0;

    lc3b_word imem_array [mem_words];
    lc3b_word dmem_array [mem_words];  // seen by the DUT
    lc3b_word model_mem  [mem_words];  // ISA model copy
    lc3b_word model_reg  [8];
    logic [2:0] model_cc;

    // expected events, in program order
    lc3b_word exp_fetch [$];
    logic     exp_write [$];
    lc3b_word exp_addr  [$];
    lc3b_word exp_wdata [$];

    int       fetch_errors = 0;
    int       data_errors = 0;
    int       other_errors = 0;
    int       prop_errors;
    logic     fetch_seen = 1'b0;
    lc3b_word want_addr;
    lc3b_word want_data;
    logic     want_write;

    lc3b_core lc3b_core_inst
    (
        .clk,
        .reset,
        .i_mem_address,
        .i_mem_read,
        .i_mem_resp,
        .i_mem_rdata,
        .d_mem_address,
        .d_mem_read,
        .d_mem_write,
        .d_mem_wdata,
        .d_mem_rdata,
        .d_mem_resp
    );

    always #2 clk = ~clk;

    function automatic int rand_below(int n);
        return int'($unsigned($random(prog_seed)) % n);
    endfunction

    function automatic lc3b_word fill_word(int idx);
        lc3b_word a;
        a = 16'(idx * 2);
        return (a * 16'h9e37) ^ {a[7:0], a[15:8]};
    endfunction

    function automatic logic [2:0] cc_of(lc3b_word v);
        if (v[15])
            return 3'b100;
        else if (v == 16'h0000)
            return 3'b010;
        else
            return 3'b001;
    endfunction

    task automatic fill_memories();
        for (int i = 0; i < mem_words; i++)
        begin
            imem_array[i] = 16'h0000;  // BR nzp 000, a NOP
            dmem_array[i] = fill_word(i);
            model_mem[i]  = fill_word(i);
        end
        for (int r = 0; r < 8; r++)
        begin
            model_reg[r] = 16'h0000;
        end
        model_cc = 3'b010;
    endtask

    // ISA behavior of one group, next_pc skips the delay NOPs
    task automatic execute_group(input lc3b_word ins, input lc3b_word pc,
                                 output lc3b_word next_pc);
        lc3b_opcode op;
        logic [2:0] dr;
        logic [2:0] sr1;
        lc3b_word   src2;
        lc3b_word   addr;
        lc3b_word   off9x2;
        op      = lc3b_opcode'(ins[15:12]);
        dr      = ins[11:9];
        sr1     = ins[8:6];
        off9x2  = {{6{ins[8]}}, ins[8:0], 1'b0};
        src2    = ins[5] ? {{11{ins[4]}}, ins[4:0]} : model_reg[ins[2:0]];
        addr    = model_reg[sr1] + {{9{ins[5]}}, ins[5:0], 1'b0};
        next_pc = pc + 16'd10;
        case (op)
            op_add:
            begin
                model_reg[dr] = model_reg[sr1] + src2;
                model_cc = cc_of(model_reg[dr]);
            end
            op_and:
            begin
                model_reg[dr] = model_reg[sr1] & src2;
                model_cc = cc_of(model_reg[dr]);
            end
            op_not:
            begin
                model_reg[dr] = ~model_reg[sr1];
                model_cc = cc_of(model_reg[dr]);
            end
            op_lea: model_reg[dr] = pc + 16'd2 + off9x2;  // cc untouched
            op_ldr:
            begin
                model_reg[dr] = model_mem[addr[15:1]];
                model_cc = cc_of(model_reg[dr]);
                exp_write.push_back(1'b0);
                exp_addr.push_back(addr);
                exp_wdata.push_back(16'h0000);
            end
            op_str:
            begin
                model_mem[addr[15:1]] = model_reg[dr];
                exp_write.push_back(1'b1);
                exp_addr.push_back(addr);
                exp_wdata.push_back(model_reg[dr]);
            end
            op_br:
            begin
                if ((dr & model_cc) != 3'b000)
                    next_pc = pc + 16'd2 + off9x2;
            end
            op_jmp: next_pc = model_reg[sr1];
            default: ;
        endcase
    endtask

    // random groups in execution order, all targets lie ahead
    task automatic build_program();
        int         g;
        int         k;
        int         kind;
        int         tg;
        logic       pending_jmp;
        logic [2:0] jmp_reg;
        logic [2:0] ra;
        logic [2:0] rb;
        logic [2:0] rc;
        lc3b_word   pc;
        lc3b_word   next_pc;
        lc3b_word   ins;
        g = 0;
        pc = reset_pc;
        pending_jmp = 1'b0;
        jmp_reg = 3'd0;
        while (g < num_groups)
        begin
            ra = 3'(rand_below(8));
            rb = 3'(rand_below(8));
            rc = 3'(rand_below(8));
            tg = g + 1 + rand_below(6);
            kind = rand_below(11);
            if (pending_jmp)
                kind = 11;
            else if (kind == 9 && g + 2 > num_groups)
                kind = 0;   // no room left for lea plus jmp
            if (kind == 9)
                tg = tg + 1;
            if (tg > num_groups)
                tg = num_groups;
            case (kind)
                0: ins = {op_add, ra, rb, 1'b0, 2'b00, rc};
                1: ins = {op_add, ra, rb, 1'b1, 5'(rand_below(32))};
                2: ins = {op_and, ra, rb, 1'b0, 2'b00, rc};
                3: ins = {op_and, ra, rb, 1'b1, 5'(rand_below(32))};
                4: ins = {op_not, ra, rb, 6'h3f};
                5: ins = {op_lea, ra, 9'(rand_below(512))};
                6: ins = {op_ldr, ra, rb, 6'(rand_below(64))};
                7, 10: ins = {op_str, ra, rb, 6'(rand_below(64))};
                8: ins = {op_br, ra, 9'(5 * (tg - g) - 1)};  // ra as nzp
                9:
                begin
                    ins = {op_lea, ra, 9'(5 * (tg - g) - 1)};  // target of the next jmp
                    jmp_reg = ra;
                    pending_jmp = 1'b1;
                end
                default:
                begin
                    ins = {op_jmp, 3'b000, jmp_reg, 6'b000000};
                    pending_jmp = 1'b0;
                end
            endcase
            imem_array[pc[15:1]] = ins;
            for (k = 0; k < 5; k++)
            begin
                exp_fetch.push_back(pc + 16'(2 * k));
            end
            execute_group(ins, pc, next_pc);
            pc = next_pc;
            g = int'(pc) / 10;
        end
        // trailing NOPs drain the last instruction
        for (k = 0; k < 5; k++)
        begin
            exp_fetch.push_back(pc + 16'(2 * k));
        end
    endtask

    // instruction memory, 0 to 3 wait cycles
    always @(posedge clk)
    begin
        if (reset)
        begin
            i_mem_resp <= 1'b0;
            i_wait <= 2'(($unsigned($random(i_seed))) % 4);
        end
        else if (i_mem_resp)
        begin
            i_mem_resp <= 1'b0;
            i_wait <= 2'(($unsigned($random(i_seed))) % 4);
        end
        else if (i_mem_read)
        begin
            if (i_wait == 2'd0)
            begin
                i_mem_resp <= 1'b1;
                i_mem_rdata <= imem_array[i_mem_address[15:1]];
            end
            else
                i_wait <= i_wait - 2'd1;
        end
        else
            i_wait <= 2'(($unsigned($random(i_seed))) % 4);  // request dropped
    end

    // data memory
    always @(posedge clk)
    begin
        if (reset)
        begin
            d_mem_resp <= 1'b0;
            d_wait <= 2'(($unsigned($random(d_seed))) % 4);
        end
        else if (d_mem_resp)
        begin
            d_mem_resp <= 1'b0;
            d_wait <= 2'(($unsigned($random(d_seed))) % 4);
        end
        else if (d_mem_read || d_mem_write)
        begin
            if (d_wait == 2'd0)
            begin
                d_mem_resp <= 1'b1;
                if (d_mem_write)
                    dmem_array[d_mem_address[15:1]] <= d_mem_wdata;
                else
                    d_mem_rdata <= dmem_array[d_mem_address[15:1]];
            end
            else
                d_wait <= d_wait - 2'd1;
        end
        else
            d_wait <= 2'(($unsigned($random(d_seed))) % 4);
    end

    // compare accepted fetches and data accesses with the model
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (!fetch_seen)
            begin
                assert (!d_mem_read && !d_mem_write)
                else
                begin
                    $display("data port active before the first fetch after reset");
                    other_errors++;
                end
            end
            if (i_mem_resp && exp_fetch.size() != 0)
            begin
                fetch_seen = 1'b1;
                want_addr = exp_fetch.pop_front();
                assert (i_mem_address == want_addr)
                else
                begin
                    $display("CHECK FAILED fetch_order expected %h actual %h",
                             want_addr, i_mem_address);
                    fetch_errors++;
                end
            end
            if (d_mem_resp)
            begin
                if (exp_write.size() == 0)
                begin
                    $display("data access at %h that the program does not make", d_mem_address);
                    other_errors++;
                end
                else
                begin
                    want_write = exp_write.pop_front();
                    want_addr = exp_addr.pop_front();
                    want_data = exp_wdata.pop_front();
                    assert (d_mem_write == want_write && d_mem_read == !want_write)
                    else
                    begin
                        $display("CHECK FAILED access_kind expected write %0d actual write %0d",
                                 want_write, d_mem_write);
                        data_errors++;
                    end
                    assert (d_mem_address == want_addr)
                    else
                    begin
                        $display("CHECK FAILED data_address expected %h actual %h",
                                 want_addr, d_mem_address);
                        data_errors++;
                    end
                    if (want_write)
                    begin
                        assert (d_mem_wdata == want_data)
                        else
                        begin
                            $display("CHECK FAILED store_data expected %h actual %h",
                                     want_data, d_mem_wdata);
                            data_errors++;
                        end
                    end
                end
            end
        end
    end

    initial
    begin
        int cycles;
        cycles = 0;
        fill_memories();
        build_program();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        while ((exp_fetch.size() != 0 || exp_write.size() != 0) && cycles < max_cycles)
        begin
            @(posedge clk);
            cycles++;
        end
        if (exp_fetch.size() != 0 || exp_write.size() != 0)
        begin
            $display("timeout after %0d cycles with %0d fetches and %0d data accesses missing",
                     cycles, exp_fetch.size(), exp_write.size());
            other_errors++;
        end
        prop_errors = lc3b_core_inst.lc3b_core_properties_inst.failures;
        $display("errors: fetch %0d, data %0d, other %0d, properties %0d",
                 fetch_errors, data_errors, other_errors, prop_errors);
        if (fetch_errors + data_errors + other_errors + prop_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* lc3b_core_properties.sv */
module lc3b_core_properties
(
    input logic               clk,
    input logic               reset,
    input logic               i_mem_read,
    input lc3b_pkg::lc3b_word d_mem_address,
    input logic               d_mem_read,
    input logic               d_mem_write,
    input lc3b_pkg::lc3b_word d_mem_wdata,
    input logic               d_mem_resp
);

    int   failures = 0;
    logic d_wait;

    // data request outstanding, no answer yet
    assign d_wait = (d_mem_read || d_mem_write) && !d_mem_resp;

    read_write_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(d_mem_read && d_mem_write))
    else
    begin
        $error("data read and write asserted together");
        failures++;
    end

    // address, data and request level held while waiting
    data_request_stable: assert property (
        @(posedge clk) disable iff (reset)
        d_wait |=> $stable(d_mem_address) && $stable(d_mem_wdata)
            && $stable(d_mem_read) && $stable(d_mem_write))
    else
    begin
        $error("data request changed before its response");
        failures++;
    end

    fetch_idle_in_stall: assert property (
        @(posedge clk) disable iff (reset)
        d_wait |-> !i_mem_read)
    else
    begin
        $error("instruction read high during a data stall");
        failures++;
    end

endmodule

bind lc3b_core lc3b_core_properties lc3b_core_properties_inst
(
    .clk           (clk),
    .reset         (reset),
    .i_mem_read    (i_mem_read),
    .d_mem_address (d_mem_address),
    .d_mem_read    (d_mem_read),
    .d_mem_write   (d_mem_write),
    .d_mem_wdata   (d_mem_wdata),
    .d_mem_resp    (d_mem_resp)
);

/* lc3b_core.sv */
module lc3b_core
(
    input  logic               clk,
    input  logic               reset,
    output lc3b_pkg::lc3b_word i_mem_address,
    output logic               i_mem_read,
    input  logic               i_mem_resp,
    input  lc3b_pkg::lc3b_word i_mem_rdata,
    output lc3b_pkg::lc3b_word d_mem_address,
    output logic               d_mem_read,
    output logic               d_mem_write,
    output lc3b_pkg::lc3b_word d_mem_wdata,
    input  lc3b_pkg::lc3b_word d_mem_rdata,
    input  logic               d_mem_resp
);

    mem_if imem ();
    mem_if dmem ();

    // instruction port, write side stays unused
    assign i_mem_address = imem.address;
    assign i_mem_read    = imem.read;
    assign imem.rdata    = i_mem_rdata;
    assign imem.resp     = i_mem_resp;

    assign d_mem_address = dmem.address;
    assign d_mem_read    = dmem.read;
    assign d_mem_write   = dmem.write;
    assign d_mem_wdata   = dmem.wdata;
    assign dmem.rdata    = d_mem_rdata;
    assign dmem.resp     = d_mem_resp;

    datapath datapath_inst
    (
        .clk,
        .reset,
        .imem (imem.core),
        .dmem (dmem.core)
    );

endmodule

/* datapath.sv */
module datapath
(
    input logic clk,
    input logic reset,
    mem_if.core imem,
    mem_if.core dmem
);
    import lc3b_pkg::*;

    decode_if dec ();

    logic       advance;
    logic       stall_d;
    logic       d_done;     // data access answered, waiting for the fetch
    lc3b_word   mdr;

    lc3b_word   pc;
    lc3b_word   pc_plus2;
    lc3b_word   pc_next;
    logic [1:0] pcmux_sel;
    logic       br_taken;

    lc3b_instr  ir_id;
    lc3b_word   pc_id;
    lc3b_word   sr1_out;
    lc3b_word   sr2_out;
    lc3b_word   imm5_sext;
    lc3b_word   opb_id;
    logic [2:0] src_b;

    lc3b_instr  ir_ex;
    lc3b_word   pc_ex;
    lc3b_word   sr1_ex;
    lc3b_word   opb_ex;
    lc3b_word   off6_ex;
    lc3b_word   off9_ex;
    lc3b_word   alu_a;
    lc3b_word   alu_b;
    lc3b_word   alu_out;
    logic       alumux1_sel_ex;
    logic [1:0] alumux2_sel_ex;
    lc3b_aluop  aluop_ex;
    logic       mem_read_ex;
    logic       mem_write_ex;
    logic       load_regfile_ex;
    logic       regfilemux_sel_ex;
    logic       load_cc_ex;
    logic [1:0] pcmux_sel_ex;
    logic       branch_ex;

    lc3b_word   alu_mem;
    lc3b_word   wdata_mem;
    lc3b_word   base_mem;
    logic [2:0] dest_mem;
    logic       mem_read_mem;
    logic       mem_write_mem;
    logic       load_regfile_mem;
    logic       regfilemux_sel_mem;
    logic       load_cc_mem;
    logic [1:0] pcmux_sel_mem;
    logic       branch_mem;

    lc3b_word   alu_wb;
    lc3b_word   mem_wb;
    lc3b_word   base_wb;
    lc3b_word   regfile_in;
    logic [2:0] dest_wb;    // nzp for a branch
    logic       load_regfile_wb;
    logic       regfilemux_sel_wb;
    logic       load_cc_wb;
    logic [1:0] pcmux_sel_wb;
    logic       branch_wb;
    logic [2:0] gencc;
    logic [2:0] cc;

    // stall and advance
    assign stall_d = (mem_read_mem | mem_write_mem) & ~dmem.resp & ~d_done;
    assign advance = imem.resp & ~stall_d;

    // fetch
    assign imem.address = pc;
    assign imem.read    = ~imem.resp & ~stall_d;
    assign imem.write   = 1'b0;
    assign imem.wdata   = '0;
    assign pc_plus2     = pc + 16'd2;

    assign br_taken  = |(dest_wb & cc);
    assign pcmux_sel = (branch_wb && !br_taken) ? 2'b00 : pcmux_sel_wb;

    always_comb
    begin
        case (pcmux_sel)
            2'b01:   pc_next = alu_wb;
            2'b10:   pc_next = base_wb;
            default: pc_next = pc_plus2;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pc       <= reset_pc;
            ir_id    <= '0;     // BR nzp 000
            d_done   <= 1'b0;
            cc       <= 3'b010;
        end
        else
        begin
            if (advance)
            begin
                pc       <= pc_next;
                ir_id    <= imem.rdata;
            end
            if (advance)
                d_done <= 1'b0;
            else if (dmem.resp)
                d_done <= 1'b1;
            if (advance && load_cc_wb)
                cc <= gencc;
        end
    end

    // decode
    assign dec.instr = ir_id;
    assign src_b     = dec.sr2_sel ? ir_id.alu.dr : ir_id.alu.imm5[2:0];
    assign imm5_sext = {{11{ir_id.alu.imm5[4]}}, ir_id.alu.imm5};
    assign opb_id    = dec.imm_sel ? imm5_sext : sr2_out;

    lc3b_decode decode_inst
    (
        .dec(dec.decoder)
    );

    lc3b_regfile regfile_inst
    (
        .clk,
        .reset,
        .load  (load_regfile_wb & advance),
        .dest  (dest_wb),
        .in    (regfile_in),
        .src_a (ir_id.alu.sr1),
        .src_b (src_b),
        .reg_a (sr1_out),
        .reg_b (sr2_out)
    );

    // execute
    assign off6_ex = {{9{ir_ex.off.offset6[5]}}, ir_ex.off.offset6, 1'b0};
    assign off9_ex = {{6{ir_ex.word[8]}}, ir_ex.word[8:0], 1'b0};
    assign alu_a   = alumux1_sel_ex ? pc_ex : sr1_ex;

    always_comb
    begin
        case (alumux2_sel_ex)
            2'b00:   alu_b = opb_ex;
            2'b01:   alu_b = off6_ex;
            default: alu_b = off9_ex;
        endcase
    end

    lc3b_alu alu_inst
    (
        .aluop (aluop_ex),
        .a     (alu_a),
        .b     (alu_b),
        .f     (alu_out)
    );

    // memory stage drives the data port, held until resp
    assign dmem.address = alu_mem;
    assign dmem.wdata   = wdata_mem;
    assign dmem.read    = mem_read_mem & ~d_done;
    assign dmem.write   = mem_write_mem & ~d_done;

    // writeback
    assign regfile_in = regfilemux_sel_wb ? mem_wb : alu_wb;
    assign gencc[2]   = regfile_in[15];
    assign gencc[1]   = (regfile_in == '0);
    assign gencc[0]   = ~regfile_in[15] & (regfile_in != '0);

    // stage control registers
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            alumux1_sel_ex     <= 1'b0;
            alumux2_sel_ex     <= 2'b00;
            aluop_ex           <= alu_pass;
            mem_read_ex        <= 1'b0;
            mem_write_ex       <= 1'b0;
            load_regfile_ex    <= 1'b0;
            regfilemux_sel_ex  <= 1'b0;
            load_cc_ex         <= 1'b0;
            pcmux_sel_ex       <= 2'b00;
            branch_ex          <= 1'b0;
            mem_read_mem       <= 1'b0;
            mem_write_mem      <= 1'b0;
            load_regfile_mem   <= 1'b0;
            regfilemux_sel_mem <= 1'b0;
            load_cc_mem        <= 1'b0;
            pcmux_sel_mem      <= 2'b00;
            branch_mem         <= 1'b0;
            load_regfile_wb    <= 1'b0;
            regfilemux_sel_wb  <= 1'b0;
            load_cc_wb         <= 1'b0;
            pcmux_sel_wb       <= 2'b00;
            branch_wb          <= 1'b0;
        end
        else if (advance)
        begin
            alumux1_sel_ex     <= dec.alumux1_sel;
            alumux2_sel_ex     <= dec.alumux2_sel;
            aluop_ex           <= dec.aluop;
            mem_read_ex        <= dec.mem_read;
            mem_write_ex       <= dec.mem_write;
            load_regfile_ex    <= dec.load_regfile;
            regfilemux_sel_ex  <= dec.regfilemux_sel;
            load_cc_ex         <= dec.load_cc;
            pcmux_sel_ex       <= dec.pcmux_sel;
            branch_ex          <= dec.branch;
            mem_read_mem       <= mem_read_ex;
            mem_write_mem      <= mem_write_ex;
            load_regfile_mem   <= load_regfile_ex;
            regfilemux_sel_mem <= regfilemux_sel_ex;
            load_cc_mem        <= load_cc_ex;
            pcmux_sel_mem      <= pcmux_sel_ex;
            branch_mem         <= branch_ex;
            load_regfile_wb    <= load_regfile_mem;
            regfilemux_sel_wb  <= regfilemux_sel_mem;
            load_cc_wb         <= load_cc_mem;
            pcmux_sel_wb       <= pcmux_sel_mem;
            branch_wb          <= branch_mem;
        end
    end

    // stage payload registers
    always_ff @(posedge clk)
    begin
        if (dmem.resp)
            mdr <= dmem.rdata;
        if (advance)
        begin
            pc_id     <= pc_plus2;
            ir_ex     <= ir_id;
            pc_ex     <= pc_id;
            sr1_ex    <= sr1_out;
            opb_ex    <= opb_id;    // also the store data
            alu_mem   <= alu_out;
            wdata_mem <= opb_ex;
            base_mem  <= sr1_ex;
            dest_mem  <= ir_ex.alu.dr;
            alu_wb    <= alu_mem;
            mem_wb    <= d_done ? mdr : dmem.rdata;
            base_wb   <= base_mem;
            dest_wb   <= dest_mem;
        end
    end

endmodule

/* lc3b_alu.sv */
module lc3b_alu
(
    input  lc3b_pkg::lc3b_aluop aluop,
    input  lc3b_pkg::lc3b_word  a,
    input  lc3b_pkg::lc3b_word  b,
    output lc3b_pkg::lc3b_word  f
);
    import lc3b_pkg::*;

    always_comb
    begin
        case (aluop)
            alu_add:  f = a + b;    // also address and pc-relative sums
            alu_and:  f = a & b;
            alu_not:  f = ~a;
            alu_pass: f = a;
            default:  f = a;
        endcase
    end

endmodule

/* lc3b_regfile.sv */
module lc3b_regfile
(
    input  logic               clk,
    input  logic               reset,
    input  logic               load,
    input  logic [2:0]         dest,
    input  lc3b_pkg::lc3b_word in,
    input  logic [2:0]         src_a,
    input  logic [2:0]         src_b,
    output lc3b_pkg::lc3b_word reg_a,
    output lc3b_pkg::lc3b_word reg_b
);
    import lc3b_pkg::*;

    lc3b_word data [8];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < 8; i++)
            begin
                data[i] <= '0;
            end
        end
        else if (load)
        begin
            data[dest] <= in;
        end
    end

    // write-first, a same-cycle read sees the incoming value
    assign reg_a = (load && dest == src_a) ? in : data[src_a];
    assign reg_b = (load && dest == src_b) ? in : data[src_b];

endmodule

/* lc3b_decode.sv */
module lc3b_decode
(
    decode_if.decoder dec
);
    import lc3b_pkg::*;

    lc3b_opcode opcode;

    assign opcode = dec.instr.alu.opcode;

    always_comb
    begin
        // everything starts out as a NOP
        dec.sr2_sel        = 1'b0;
        dec.imm_sel        = 1'b0;
        dec.alumux1_sel    = 1'b0;
        dec.alumux2_sel    = 2'b00;
        dec.aluop          = alu_pass;
        dec.mem_read       = 1'b0;
        dec.mem_write      = 1'b0;
        dec.load_regfile   = 1'b0;
        dec.regfilemux_sel = 1'b0;
        dec.load_cc        = 1'b0;
        dec.pcmux_sel      = 2'b00;
        dec.branch         = 1'b0;

        case (opcode)
            op_add, op_and:
            begin
                dec.imm_sel      = dec.instr.alu.imm_flag;
                dec.aluop        = (opcode == op_add) ? alu_add : alu_and;
                dec.load_regfile = 1'b1;
                dec.load_cc      = 1'b1;
            end
            op_not:
            begin
                dec.aluop        = alu_not;
                dec.load_regfile = 1'b1;
                dec.load_cc      = 1'b1;
            end
            op_lea:
            begin
                dec.alumux1_sel  = 1'b1;    // pc + offset9
                dec.alumux2_sel  = 2'b10;
                dec.aluop        = alu_add;
                dec.load_regfile = 1'b1;
            end
            op_ldr:
            begin
                dec.alumux2_sel    = 2'b01; // base + offset6
                dec.aluop          = alu_add;
                dec.mem_read       = 1'b1;
                dec.load_regfile   = 1'b1;
                dec.regfilemux_sel = 1'b1;
                dec.load_cc        = 1'b1;
            end
            op_str:
            begin
                dec.sr2_sel     = 1'b1;     // store source sits in the dr field
                dec.alumux2_sel = 2'b01;
                dec.aluop       = alu_add;
                dec.mem_write   = 1'b1;
            end
            op_br:
            begin
                dec.alumux1_sel = 1'b1;
                dec.alumux2_sel = 2'b10;
                dec.aluop       = alu_add;
                dec.pcmux_sel   = 2'b01;
                dec.branch      = 1'b1;
            end
            op_jmp:
            begin
                dec.pcmux_sel = 2'b10;      // base register carried to writeback
            end
            default: ;
        endcase
    end

endmodule

/* decode_if.sv */
interface decode_if;
    import lc3b_pkg::*;

    lc3b_instr  instr;
    logic       sr2_sel;        // 1: dr field feeds the second read port (store data)
    logic       imm_sel;        // 1: sign-extended imm5 replaces sr2
    logic       alumux1_sel;    // 0: sr1, 1: pc
    logic [1:0] alumux2_sel;    // 0: sr2/imm, 1: offset6, 2: offset9
    lc3b_aluop  aluop;
    logic       mem_read;
    logic       mem_write;
    logic       load_regfile;
    logic       regfilemux_sel; // 0: alu, 1: memory
    logic       load_cc;
    logic [1:0] pcmux_sel;      // 0: pc+2, 1: alu result, 2: jmp base
    logic       branch;         // redirect only on an nzp match

    modport decoder
    (
        input  instr,
        output sr2_sel, imm_sel, alumux1_sel, alumux2_sel, aluop,
        output mem_read, mem_write, load_regfile, regfilemux_sel,
        output load_cc, pcmux_sel, branch
    );

    modport datapath
    (
        output instr,
        input  sr2_sel, imm_sel, alumux1_sel, alumux2_sel, aluop,
        input  mem_read, mem_write, load_regfile, regfilemux_sel,
        input  load_cc, pcmux_sel, branch
    );

endinterface

/* mem_if.sv */
interface mem_if;
    import lc3b_pkg::*;

    lc3b_word address;
    logic     read;
    logic     write;    // held low on the instruction port
    lc3b_word wdata;
    lc3b_word rdata;
    logic     resp;     // one-cycle pulse with rdata

    modport core
    (
        output address,
        output read,
        output write,
        output wdata,
        input  rdata,
        input  resp
    );

    modport top
    (
        input  address,
        input  read,
        input  write,
        input  wdata,
        output rdata,
        output resp
    );

endinterface

/* lc3b_pkg.sv */
package lc3b_pkg;

    typedef logic [15:0] lc3b_word;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,  // not implemented
        op_stb  = 4'b0011,  // not implemented
        op_jsr  = 4'b0100,  // not implemented
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,  // not implemented
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,  // not implemented
        op_sti  = 4'b1011,  // not implemented
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,  // not implemented
        op_lea  = 4'b1110,
        op_trap = 4'b1111   // not implemented
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    // one instruction word, seen as ALU format or as base/offset format
    typedef union packed {
        lc3b_word word;     // pc offset9 comes from the low bits here
        struct packed {
            lc3b_opcode opcode;
            logic [2:0] dr;
            logic [2:0] sr1;
            logic       imm_flag;
            logic [4:0] imm5;   // sr2 in bits 2:0 when imm_flag is clear
        } alu;
        struct packed {
            lc3b_opcode opcode;
            logic [2:0] dr_nzp; // dest, store source or branch nzp
            logic [2:0] base;
            logic [5:0] offset6;
        } off;
    } lc3b_instr;

    // first fetch address out of reset
    localparam lc3b_word reset_pc = 16'h0000;

endpackage
